//--- test/missunit_input.txt
# op port paddr size nc id wdata vld_bits ack_dly rdata exp_way exp_miss
# ops: E enable, F flush, S store, X stray store ack, L load, P two reads plus store
E 0 0000 0 0 0 00000000 0 0 0000000000000000 0 0
S 2 1234 2 0 1 deadbeef 0 0 0000000000000000 0 0
S 2 2237 1 0 2 cafe0001 0 2 0000000000000000 0 0
X 2 0000 0 0 3 00000000 0 0 0000000000000000 0 0
L 0 4a18 3 0 1 00000000 1 1 1122334455667788 1 1
L 1 0c40 3 0 2 00000000 3 0 a5a5a5a55a5a5a5a 2 1
L 0 8010 3 1 3 00000000 7 0 0102030405060708 3 0
L 1 f3f8 2 1 0 00000000 0 3 ffeeddccbbaa9988 0 0
F 0 0000 0 0 0 00000000 0 0 0000000000000000 0 0
S 2 7ff8 3 0 0 12345678 0 1 0000000000000000 0 0
P 0 1a08 3 0 0 0badf00d 0 0 0f1e2d3c4b5a6978 0 1
L 0 6628 3 0 2 00000000 e 2 1357924680acebdf 0 1
X 2 0000 0 0 1 00000000 0 0 0000000000000000 0 0

//--- files.f
src/missunit_pkg.sv
src/miss_ctrl.sv
src/miss_arbiter.sv
src/mshr.sv
src/rtrn_unit.sv
src/line_writer.sv
src/dcache_missunit.sv
test/tb_dcache_missunit.sv

//--- run.sh
#!/bin/sh
# build and run the miss unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
  --top-module tb_dcache_missunit -o tb_sim -f files.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

//--- test/tb_dcache_missunit.sv
`timescale 1ns/1ps

module tb_dcache_missunit;

  typedef struct {
    string       op;
    logic [1:0]  port;
    logic [15:0] paddr;
    logic [2:0]  size;
    logic        nc;
    logic [1:0]  id;
    logic [31:0] wdata;
    logic [3:0]  vld_bits;
    int          ack_dly;
    logic [63:0] rdata;
    logic [1:0]  exp_way;
    logic        exp_miss;
  } step_t;

  logic clk_i, rst_ni, enable_i, flush_i, wbuffer_empty_i;
  logic flush_ack_o, miss_o, cache_en_o;
  logic [2:0] miss_req_i, miss_ack_o, miss_rtrn_vld_o;
  logic [1:0] miss_rtrn_id_o;
  missunit_pkg::miss_req_t [2:0] miss_port_i;
  logic mem_data_req_o, mem_data_ack_i, mem_rtrn_vld_i;
  missunit_pkg::mem_req_t  mem_data_o;
  missunit_pkg::mem_rtrn_t mem_rtrn_i;
  missunit_pkg::cl_wr_t    wr_cl_o;

  step_t  steps[$];
  integer seed = 10;
  bit     steps_loaded = 0;

  dcache_missunit u_dcache_missunit (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_mem_req(input string name, input missunit_pkg::mem_req_t exp,
                               input missunit_pkg::mem_req_t act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
      abort_run("memory request mismatch");
    end
  endtask

  task automatic check_cl_wr(input string name, input missunit_pkg::cl_wr_t exp,
                             input missunit_pkg::cl_wr_t act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
      abort_run("cache write mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
      abort_run("control bit mismatch");
    end
  endtask

  task automatic check_rtrn(input logic [2:0] exp_vld, input logic [1:0] exp_id);
    if (exp_vld !== miss_rtrn_vld_o || (exp_vld != 0 && exp_id !== miss_rtrn_id_o)) begin
      $display("FAIL %0t miss_rtrn_vld_o/id expected %b/%h got %b/%h", $time,
               exp_vld, exp_id, miss_rtrn_vld_o, miss_rtrn_id_o);
      abort_run("return mismatch");
    end
  endtask

  // flush leaves nc, tag and data undefined
  function automatic missunit_pkg::cl_wr_t flush_view(input missunit_pkg::cl_wr_t wr);
    flush_view      = wr;
    flush_view.nc   = 1'b0;
    flush_view.tag  = '0;
    flush_view.data = '0;
  endfunction

  // clear the address bits below the access size
  function automatic logic [15:0] align_addr(input logic [15:0] a, input logic [2:0] size);
    logic [15:0] mask;
    mask = (size >= 3) ? 16'h7 : ((16'h1 << size) - 16'h1);
    return a & ~mask;
  endfunction

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic collect_flush(input bit from_flush, input bit exp_en);
    missunit_pkg::cl_wr_t exp;
    @(negedge clk_i);
    while (!wr_cl_o.vld) @(negedge clk_i);
    for (int i = 0; i < 16; i++) begin
      exp     = '0;
      exp.vld = 1'b1;
      exp.we  = 4'hf;
      exp.idx = 4'(i);
      check_cl_wr("wr_cl_o", exp, flush_view(wr_cl_o));
      check_bit("flush_ack_o", from_flush && i == 15, flush_ack_o);
      @(negedge clk_i);
    end
    check_bit("cache_en_o", exp_en, cache_en_o);
  endtask

  task automatic drive_port(input step_t s, input logic [1:0] p, input logic [15:0] a,
                            input logic [1:0] id);
    miss_port_i[p].we       = (p == 2);
    miss_port_i[p].nc       = s.nc;
    miss_port_i[p].paddr    = a;
    miss_port_i[p].size     = s.size;
    miss_port_i[p].wdata    = s.wdata;
    miss_port_i[p].id       = id;
    miss_port_i[p].vld_bits = s.vld_bits;
    miss_req_i[p]           = 1'b1;
  endtask

  task automatic wait_req();
    @(negedge clk_i);
    while (!mem_data_req_o) @(negedge clk_i);
  endtask

  // ack after the delay, check the transfer cycle, then drop the port
  task automatic ack_req(input step_t s, input logic [1:0] p, input logic [15:0] a,
                         input logic [1:0] id);
    missunit_pkg::mem_req_t exp;
    exp.rtype = (p == 2) ? missunit_pkg::REQ_STORE : missunit_pkg::REQ_LOAD;
    exp.tid   = id;
    exp.nc    = s.nc;
    exp.way   = (p == 2) ? 2'd0 : s.exp_way;
    exp.paddr = align_addr(a, s.size);
    exp.size  = s.size;
    exp.data  = s.wdata;
    repeat (s.ack_dly) @(posedge clk_i);
    @(posedge clk_i);
    #2 mem_data_ack_i = 1'b1;
    @(negedge clk_i);
    check_bit("mem_data_req_o", 1'b1, mem_data_req_o);
    check_mem_req("mem_data_o", exp, mem_data_o);
    check_bit("miss_ack_o", 1'b1, miss_ack_o[p]);
    check_bit("miss_o", (p == 2) ? 1'b0 : s.exp_miss, miss_o);
    @(posedge clk_i);
    #2 mem_data_ack_i = 1'b0;
    miss_req_i[p] = 1'b0;
  endtask

  task automatic send_rtrn(input missunit_pkg::rtrn_type_e t, input logic [1:0] tid,
                           input logic [63:0] data, input bit random_dly);
    if (random_dly) begin
      repeat ($unsigned($random(seed)) % 4) @(posedge clk_i);
    end
    @(posedge clk_i);
    #2 mem_rtrn_vld_i = 1'b1;
    mem_rtrn_i.rtype = t;
    mem_rtrn_i.tid   = tid;
    mem_rtrn_i.data  = data;
  endtask

  task automatic end_rtrn();
    @(posedge clk_i);
    #2 mem_rtrn_vld_i = 1'b0;
  endtask

  // load return fills a line only for cacheable loads
  task automatic check_load_rtrn(input step_t s, input logic [1:0] p, input logic [15:0] a,
                                 input logic [1:0] id);
    missunit_pkg::cl_wr_t exp;
    exp          = '0;
    exp.vld      = 1'b1;
    exp.nc       = s.nc;
    exp.tag      = a[15:7];
    exp.idx      = a[6:3];
    exp.data     = s.rdata;
    if (!s.nc) begin
      exp.we       = 4'b1 << s.exp_way;
      exp.be       = 8'hff;
      exp.vld_bits = 4'b1 << s.exp_way;
    end
    @(negedge clk_i);
    check_rtrn(3'b1 << p, id);
    check_cl_wr("wr_cl_o", exp, wr_cl_o);
  endtask

  task automatic run_step(input step_t s);
    logic [15:0] a1;
    a1 = s.paddr ^ 16'h0100;
    case (s.op)
      "E": begin
        @(posedge clk_i);
        #2 enable_i = 1'b1;
        collect_flush(1'b0, 1'b1);
      end
      "F": begin
        @(posedge clk_i);
        #2 flush_i = 1'b1;
        @(posedge clk_i);
        #2 flush_i = 1'b0;
        collect_flush(1'b1, 1'b1);
      end
      "S": begin
        @(posedge clk_i);
        #2 drive_port(s, 2, s.paddr, s.id);
        wait_req();
        ack_req(s, 2, s.paddr, s.id);
        send_rtrn(missunit_pkg::RTRN_STORE_ACK, s.id, s.rdata, 1'b1);
        @(negedge clk_i);
        check_rtrn(3'b100, s.id);
        end_rtrn();
      end
      "X": begin
        send_rtrn(missunit_pkg::RTRN_STORE_ACK, s.id, s.rdata, 1'b0);
        @(negedge clk_i);
        check_rtrn(3'b000, s.id);
        end_rtrn();
      end
      "L": begin
        @(posedge clk_i);
        #2 drive_port(s, s.port, s.paddr, s.id);
        wait_req();
        ack_req(s, s.port, s.paddr, s.id);
        send_rtrn(missunit_pkg::RTRN_LOAD_ACK, s.id, s.rdata, 1'b1);
        check_load_rtrn(s, s.port, s.paddr, s.id);
        end_rtrn();
      end
      "P": begin
        // two reads at once and then a store to the first read's line
        @(posedge clk_i);
        #2 drive_port(s, 0, s.paddr, s.id);
        drive_port(s, 1, a1, s.id + 2'd1);
        wait_req();
        ack_req(s, 0, s.paddr, s.id);
        drive_port(s, 2, s.paddr, s.id + 2'd2);
        repeat (3) begin
          @(negedge clk_i);
          check_bit("mem_data_req_o", 1'b0, mem_data_req_o);
        end
        send_rtrn(missunit_pkg::RTRN_LOAD_ACK, s.id, s.rdata, 1'b0);
        check_load_rtrn(s, 0, s.paddr, s.id);
        end_rtrn();
        wait_req();
        ack_req(s, 1, a1, s.id + 2'd1);
        wait_req();
        ack_req(s, 2, s.paddr, s.id + 2'd2);
        send_rtrn(missunit_pkg::RTRN_LOAD_ACK, s.id + 2'd1, s.rdata, 1'b1);
        check_load_rtrn(s, 1, a1, s.id + 2'd1);
        end_rtrn();
        send_rtrn(missunit_pkg::RTRN_STORE_ACK, s.id + 2'd2, s.rdata, 1'b1);
        @(negedge clk_i);
        check_rtrn(3'b100, s.id + 2'd2);
        end_rtrn();
      end
      default: abort_run({"unknown operation in stimulus file: ", s.op});
    endcase
  endtask

  task automatic load_steps();
    int    fd;
    int    n;
    string line;
    step_t s;
    fd = $fopen("test/missunit_input.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open test/missunit_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %d %h %h %h", s.op, s.port, s.paddr,
                      s.size, s.nc, s.id, s.wdata, s.vld_bits, s.ack_dly, s.rdata,
                      s.exp_way, s.exp_miss);
          if (n != 12) begin
            abort_run({"malformed stimulus line: ", line});
          end else begin
            steps.push_back(s);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // run length scales with the number of steps
  initial begin
    wait (steps_loaded);
    repeat ((steps.size() + 1) * 200) @(posedge clk_i);
    abort_run("timeout, the DUT stopped responding");
  end

  initial begin
    rst_ni          = 1'b0;
    enable_i        = 1'b0;
    flush_i         = 1'b0;
    wbuffer_empty_i = 1'b1;
    miss_req_i      = '0;
    miss_port_i     = '0;
    mem_data_ack_i  = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_i      = '0;
    load_steps();
    steps_loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    // the reset flush leaves the cache off
    collect_flush(1'b0, 1'b0);
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    repeat (2) @(posedge clk_i);
    $display("all tests passed");
    $finish;
  end

endmodule

//--- src/dcache_missunit.sv
`timescale 1ns/1ps

module dcache_missunit (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 enable_i,
  input  logic                                                 flush_i,
  input  logic                                                 wbuffer_empty_i,
  output logic                                                 flush_ack_o,
  output logic                                                 miss_o,
  output logic                                                 cache_en_o,
  input  logic [missunit_pkg::NUM_PORTS-1:0]                   miss_req_i,
  output logic [missunit_pkg::NUM_PORTS-1:0]                   miss_ack_o,
  input  missunit_pkg::miss_req_t [missunit_pkg::NUM_PORTS-1:0] miss_port_i,
  output logic [missunit_pkg::NUM_PORTS-1:0]                   miss_rtrn_vld_o,
  output logic [missunit_pkg::TID_WIDTH-1:0]                   miss_rtrn_id_o,
  output logic                                                 mem_data_req_o,
  input  logic                                                 mem_data_ack_i,
  output missunit_pkg::mem_req_t                               mem_data_o,
  input  logic                                                 mem_rtrn_vld_i,
  input  missunit_pkg::mem_rtrn_t                              mem_rtrn_i,
  output missunit_pkg::cl_wr_t                                 wr_cl_o
);

  // control
  logic                    lock_reqs, mask_reads, req_en, mshr_allocate, flush_en;
  missunit_pkg::req_type_e req_type;
  // arbiter
  logic                    any_req, sel_is_write;
  missunit_pkg::port_idx_t sel_port;
  // MSHR and returns
  logic                               mshr_vld, rdwr_collision, load_ack, flush_done;
  missunit_pkg::mshr_t                mshr;
  logic [missunit_pkg::WAY_WIDTH-1:0] repl_way;
  logic                               store_sent;

  // a store counts as in flight once memory accepts it
  assign store_sent = mem_data_req_o & mem_data_ack_i &
                      (mem_data_o.rtype == missunit_pkg::REQ_STORE);

  miss_ctrl u_miss_ctrl (
    .clk_i, .rst_ni, .enable_i, .flush_i, .wbuffer_empty_i,
    .any_req_i(any_req), .sel_is_write_i(sel_is_write), .mshr_vld_i(mshr_vld),
    .rdwr_collision_i(rdwr_collision), .load_ack_i(load_ack),
    .flush_done_i(flush_done), .mem_data_ack_i,
    .req_en_o(req_en), .req_type_o(req_type), .mshr_allocate_o(mshr_allocate),
    .lock_reqs_o(lock_reqs), .mask_reads_o(mask_reads), .flush_en_o(flush_en),
    .flush_ack_o, .cache_en_o
  );

  miss_arbiter u_miss_arbiter (
    .clk_i, .rst_ni, .miss_req_i, .miss_port_i,
    .lock_reqs_i(lock_reqs), .mask_reads_i(mask_reads), .req_en_i(req_en),
    .req_type_i(req_type), .repl_way_i(repl_way), .mem_data_ack_i,
    .miss_ack_o, .any_req_o(any_req), .sel_port_o(sel_port),
    .sel_is_write_o(sel_is_write), .mem_data_req_o, .mem_data_o
  );

  mshr u_mshr (
    .clk_i, .rst_ni, .mshr_allocate_i(mshr_allocate), .load_ack_i(load_ack),
    .sel_port_i(sel_port), .miss_port_i,
    .mshr_vld_o(mshr_vld), .mshr_o(mshr), .repl_way_o(repl_way),
    .rdwr_collision_o(rdwr_collision), .miss_o
  );

  rtrn_unit u_rtrn_unit (
    .clk_i, .rst_ni, .mem_rtrn_vld_i, .mem_rtrn_i,
    .mshr_vld_i(mshr_vld), .mshr_port_i(mshr.port), .mshr_id_i(mshr.id),
    .store_sent_i(store_sent),
    .load_ack_o(load_ack), .miss_rtrn_vld_o, .miss_rtrn_id_o
  );

  line_writer u_line_writer (
    .clk_i, .rst_ni, .flush_en_i(flush_en), .load_ack_i(load_ack),
    .mshr_i(mshr), .mem_rtrn_i,
    .flush_done_o(flush_done), .wr_cl_o
  );

endmodule

//--- src/line_writer.sv
`timescale 1ns/1ps

module line_writer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_en_i,
  input  logic                  load_ack_i,
  input  missunit_pkg::mshr_t   mshr_i,
  input  missunit_pkg::mem_rtrn_t mem_rtrn_i,
  output logic                  flush_done_o,
  output missunit_pkg::cl_wr_t  wr_cl_o
);

  logic [missunit_pkg::IDX_WIDTH-1:0] cnt_d, cnt_q;
  logic                               cl_write_en;
  logic [missunit_pkg::SET_ASSOC-1:0] way_oh;
  logic [missunit_pkg::SET_ASSOC-1:0] cl_we;

  // flush line counter idles at zero
  assign cnt_d        = flush_en_i ? cnt_q + 1'b1 : '0;
  assign flush_done_o = flush_en_i &&
                        (cnt_q == missunit_pkg::IDX_WIDTH'(missunit_pkg::NUM_LINES - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // only cacheable returns fill a line
  assign cl_write_en = load_ack_i & ~mshr_i.nc;

  always_comb begin
    way_oh                  = '0;
    way_oh[mshr_i.repl_way] = 1'b1;
  end

  // flush hits every way of the set
  assign cl_we = flush_en_i  ? '1 :
                 cl_write_en ? way_oh : '0;

  assign wr_cl_o.vld      = load_ack_i | (|cl_we);
  assign wr_cl_o.nc       = mshr_i.nc;
  assign wr_cl_o.we       = cl_we;
  assign wr_cl_o.tag      = mshr_i.paddr[missunit_pkg::OFFSET_WIDTH + missunit_pkg::IDX_WIDTH +:
                                         missunit_pkg::TAG_WIDTH];
  assign wr_cl_o.idx      = flush_en_i ? cnt_q :
                            mshr_i.paddr[missunit_pkg::OFFSET_WIDTH +: missunit_pkg::IDX_WIDTH];
  assign wr_cl_o.data     = mem_rtrn_i.data;
  // whole line or nothing
  assign wr_cl_o.be       = cl_write_en ? '1 : '0;
  assign wr_cl_o.vld_bits = (cl_write_en && !flush_en_i) ? way_oh : '0;

endmodule

//--- src/rtrn_unit.sv
`timescale 1ns/1ps

module rtrn_unit (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               mem_rtrn_vld_i,
  input  missunit_pkg::mem_rtrn_t            mem_rtrn_i,
  input  logic                               mshr_vld_i,
  input  missunit_pkg::port_idx_t            mshr_port_i,
  input  logic [missunit_pkg::TID_WIDTH-1:0] mshr_id_i,
  input  logic                               store_sent_i,
  output logic                               load_ack_o,
  output logic [missunit_pkg::NUM_PORTS-1:0] miss_rtrn_vld_o,
  output logic [missunit_pkg::TID_WIDTH-1:0] miss_rtrn_id_o
);

  logic [missunit_pkg::STCNT_WIDTH-1:0] stores_d, stores_q;
  logic                                 store_ack;

  // decode returns and drop acks without a matching request
  always_comb begin
    load_ack_o      = 1'b0;
    store_ack       = 1'b0;
    miss_rtrn_vld_o = '0;
    if (mem_rtrn_vld_i) begin
      unique case (mem_rtrn_i.rtype)
        missunit_pkg::RTRN_LOAD_ACK: begin
          if (mshr_vld_i) begin
            load_ack_o                   = 1'b1;
            miss_rtrn_vld_o[mshr_port_i] = 1'b1;
          end
        end
        missunit_pkg::RTRN_STORE_ACK: begin
          if (stores_q != '0) begin
            store_ack                                  = 1'b1;
            miss_rtrn_vld_o[missunit_pkg::NUM_PORTS-1] = 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // id goes back to the write buffer
  assign miss_rtrn_id_o = mem_rtrn_i.tid;

  // stores in flight
  assign stores_d = (store_ack && store_sent_i) ? stores_q :
                    store_ack                   ? stores_q - 1'b1 :
                    store_sent_i                ? stores_q + 1'b1 : stores_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stores_q <= '0;
    end else begin
      stores_q <= stores_d;
    end
  end

  a_load_tid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_ack_o |-> (mem_rtrn_i.tid == mshr_id_i))
    else $error("load return tid does not match the MSHR");

  // write buffer must not exceed the store limit
  a_store_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (store_sent_i && !store_ack) |-> (stores_q != missunit_pkg::MAX_STORES))
    else $error("too many stores in flight");

endmodule

//--- src/mshr.sv
`timescale 1ns/1ps

module mshr (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 mshr_allocate_i,
  input  logic                                                 load_ack_i,
  input  missunit_pkg::port_idx_t                              sel_port_i,
  input  missunit_pkg::miss_req_t [missunit_pkg::NUM_PORTS-1:0] miss_port_i,
  output logic                                                 mshr_vld_o,
  output missunit_pkg::mshr_t                                  mshr_o,
  output logic [missunit_pkg::WAY_WIDTH-1:0]                   repl_way_o,
  output logic                                                 rdwr_collision_o,
  output logic                                                 miss_o
);

  missunit_pkg::miss_req_t            sel_req;
  missunit_pkg::mshr_t                mshr_d, mshr_q;
  logic                               mshr_vld_d, mshr_vld_q;
  logic [missunit_pkg::WAY_WIDTH-1:0] inv_way;
  logic                               all_ways_valid;
  logic [7:0]                         lfsr_q;
  logic                               lfsr_step;

  assign sel_req        = miss_port_i[sel_port_i];
  assign all_ways_valid = &sel_req.vld_bits;

  // lowest invalid way of the requested set
  always_comb begin
    inv_way = '0;
    for (int w = missunit_pkg::SET_ASSOC - 1; w >= 0; w--) begin
      if (!sel_req.vld_bits[w]) begin
        inv_way = missunit_pkg::WAY_WIDTH'(w);
      end
    end
  end

  // full set evicts a pseudo-random way
  assign repl_way_o = all_ways_valid ? lfsr_q[missunit_pkg::WAY_WIDTH-1:0] : inv_way;
  assign lfsr_step  = mshr_allocate_i & all_ways_valid;

  // x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'h5a;
    end else if (lfsr_step) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  // capture the read at allocation
  always_comb begin
    mshr_d = mshr_q;
    if (mshr_allocate_i) begin
      mshr_d.paddr    = sel_req.paddr;
      mshr_d.nc       = sel_req.nc;
      mshr_d.id       = sel_req.id;
      mshr_d.repl_way = repl_way_o;
      mshr_d.port     = sel_port_i;
    end
  end

  // a new allocation wins over the return that frees the entry
  assign mshr_vld_d = mshr_allocate_i ? 1'b1 :
                      load_ack_i      ? 1'b0 : mshr_vld_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mshr_vld_q <= 1'b0;
      mshr_q     <= '0;
    end else begin
      mshr_vld_q <= mshr_vld_d;
      mshr_q     <= mshr_d;
    end
  end

  assign mshr_vld_o = mshr_vld_q;
  assign mshr_o     = mshr_q;
  assign miss_o     = mshr_allocate_i & ~sel_req.nc;

  // write port line against the pending read line
  assign rdwr_collision_o = mshr_vld_q &&
    (miss_port_i[missunit_pkg::NUM_PORTS-1].paddr[missunit_pkg::PADDR_WIDTH-1:
                                                  missunit_pkg::OFFSET_WIDTH] ==
     mshr_q.paddr[missunit_pkg::PADDR_WIDTH-1:missunit_pkg::OFFSET_WIDTH]);

endmodule

//--- src/miss_arbiter.sv
`timescale 1ns/1ps

module miss_arbiter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic [missunit_pkg::NUM_PORTS-1:0]                   miss_req_i,
  input  missunit_pkg::miss_req_t [missunit_pkg::NUM_PORTS-1:0] miss_port_i,
  input  logic                                                 lock_reqs_i,
  input  logic                                                 mask_reads_i,
  input  logic                                                 req_en_i,
  input  missunit_pkg::req_type_e                              req_type_i,
  input  logic [missunit_pkg::WAY_WIDTH-1:0]                   repl_way_i,
  input  logic                                                 mem_data_ack_i,
  output logic [missunit_pkg::NUM_PORTS-1:0]                   miss_ack_o,
  output logic                                                 any_req_o,
  output missunit_pkg::port_idx_t                              sel_port_o,
  output logic                                                 sel_is_write_o,
  output logic                                                 mem_data_req_o,
  output missunit_pkg::mem_req_t                               mem_data_o
);

  logic [missunit_pkg::NUM_PORTS-1:0]   req_we;
  logic [missunit_pkg::NUM_PORTS-1:0]   masked_d, masked_q;
  missunit_pkg::miss_req_t              sel_req;
  logic [missunit_pkg::PADDR_WIDTH-1:0] paddr_al;

  always_comb begin
    for (int p = 0; p < missunit_pkg::NUM_PORTS; p++) begin
      req_we[p] = miss_port_i[p].we;
    end
  end

  // frozen while a wait state holds the request
  assign masked_d  = lock_reqs_i  ? masked_q :
                     mask_reads_i ? (miss_req_i & req_we) : miss_req_i;
  assign any_req_o = |masked_d;

  // lowest index wins
  always_comb begin
    sel_port_o = '0;
    for (int p = missunit_pkg::NUM_PORTS - 1; p >= 0; p--) begin
      if (masked_d[p]) begin
        sel_port_o = missunit_pkg::port_idx_t'(p);
      end
    end
  end

  assign sel_req        = miss_port_i[sel_port_o];
  assign sel_is_write_o = sel_req.we;

  // ack goes to the chosen port in the transfer cycle
  always_comb begin
    miss_ack_o             = '0;
    miss_ack_o[sel_port_o] = req_en_i & mem_data_ack_i;
  end

  //////////////////////////////
  // outgoing request
  //////////////////////////////

  // align the address down to the access size
  always_comb begin
    paddr_al = sel_req.paddr;
    for (int b = 0; b < missunit_pkg::OFFSET_WIDTH; b++) begin
      if (b < int'(sel_req.size)) begin
        paddr_al[b] = 1'b0;
      end
    end
  end

  assign mem_data_req_o   = req_en_i;
  assign mem_data_o.rtype = req_type_i;
  assign mem_data_o.tid   = sel_req.id;
  assign mem_data_o.nc    = sel_req.nc;
  assign mem_data_o.way   = repl_way_i;
  assign mem_data_o.paddr = paddr_al;
  assign mem_data_o.size  = sel_req.size;
  assign mem_data_o.data  = sel_req.wdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      masked_q <= '0;
    end else begin
      masked_q <= masked_d;
    end
  end

  // read ports never write
  a_read_ports: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (miss_req_i[missunit_pkg::NUM_PORTS-2:0] & req_we[missunit_pkg::NUM_PORTS-2:0]) == '0)
    else $error("write request on a read port");

  // write port never reads
  a_write_port: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_req_i[missunit_pkg::NUM_PORTS-1] |-> req_we[missunit_pkg::NUM_PORTS-1])
    else $error("read request on the write port");

endmodule

//--- src/miss_ctrl.sv
`timescale 1ns/1ps

module miss_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    flush_i,
  input  logic                    wbuffer_empty_i,
  input  logic                    any_req_i,
  input  logic                    sel_is_write_i,
  input  logic                    mshr_vld_i,
  input  logic                    rdwr_collision_i,
  input  logic                    load_ack_i,
  input  logic                    flush_done_i,
  input  logic                    mem_data_ack_i,
  output logic                    req_en_o,
  output missunit_pkg::req_type_e req_type_o,
  output logic                    mshr_allocate_o,
  output logic                    lock_reqs_o,
  output logic                    mask_reads_o,
  output logic                    flush_en_o,
  output logic                    flush_ack_o,
  output logic                    cache_en_o
);

  missunit_pkg::ctrl_state_e state_d, state_q;
  logic enable_d, enable_q;
  // set when the running flush came from flush_i
  logic flush_ack_d, flush_ack_q;
  logic drained;

  assign cache_en_o = enable_q;
  // nothing left in the write buffer and no read outstanding
  assign drained    = wbuffer_empty_i & ~mshr_vld_i;

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    // the cache turns off at once but turns on only through a flush
    enable_d        = enable_q & enable_i;
    flush_ack_d     = flush_ack_q;
    flush_ack_o     = 1'b0;
    flush_en_o      = 1'b0;
    req_en_o        = 1'b0;
    req_type_o      = missunit_pkg::REQ_LOAD;
    mshr_allocate_o = 1'b0;
    lock_reqs_o     = 1'b0;
    // reads wait while the MSHR is busy, unless it frees up in this cycle
    mask_reads_o    = mshr_vld_i & ~load_ack_i;

    unique case (state_q)
      missunit_pkg::IDLE: begin
        if (flush_i || (enable_i && !enable_q)) begin
          flush_ack_d = flush_i;
          state_d     = missunit_pkg::DRAIN;
        end else if (any_req_i) begin
          if (sel_is_write_i) begin
            // write goes straight out unless it hits the pending read line
            if (!rdwr_collision_i) begin
              req_en_o   = 1'b1;
              req_type_o = missunit_pkg::REQ_STORE;
              if (!mem_data_ack_i) begin
                state_d = missunit_pkg::STORE_WAIT;
              end
            end
          end else if (!mshr_vld_i || load_ack_i) begin
            // the single MSHR is allocated on the ack
            req_en_o        = 1'b1;
            req_type_o      = missunit_pkg::REQ_LOAD;
            mshr_allocate_o = mem_data_ack_i;
            if (!mem_data_ack_i) begin
              state_d = missunit_pkg::LOAD_WAIT;
            end
          end
        end
      end

      // hold the store until memory takes it
      missunit_pkg::STORE_WAIT: begin
        lock_reqs_o = 1'b1;
        req_en_o    = 1'b1;
        req_type_o  = missunit_pkg::REQ_STORE;
        if (mem_data_ack_i) begin
          state_d = missunit_pkg::IDLE;
        end
      end

      // hold the load until memory takes it
      missunit_pkg::LOAD_WAIT: begin
        lock_reqs_o = 1'b1;
        req_en_o    = 1'b1;
        req_type_o  = missunit_pkg::REQ_LOAD;
        if (mem_data_ack_i) begin
          mshr_allocate_o = 1'b1;
          state_d         = missunit_pkg::IDLE;
        end
      end

      // stores still drain while new reads are held off
      missunit_pkg::DRAIN: begin
        mask_reads_o = 1'b1;
        if (any_req_i && !rdwr_collision_i) begin
          req_en_o   = 1'b1;
          req_type_o = missunit_pkg::REQ_STORE;
        end
        if (drained) begin
          state_d = missunit_pkg::FLUSH;
        end
      end

      // clear one line per cycle
      missunit_pkg::FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done_i) begin
          flush_ack_o = flush_ack_q;
          flush_ack_d = 1'b0;
          enable_d    = enable_i;
          state_d     = missunit_pkg::IDLE;
        end
      end

      default: begin
        state_d = missunit_pkg::FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= missunit_pkg::FLUSH;
      enable_q    <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      enable_q    <= enable_d;
      flush_ack_q <= flush_ack_d;
    end
  end

  // the MSHR only fills on an accepted load and never over a pending read
  a_alloc_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mshr_allocate_o |-> (req_en_o && mem_data_ack_i && (!mshr_vld_i || load_ack_i)))
    else $error("MSHR allocated without an accepted request or over a pending read");

endmodule

//--- src/missunit_pkg.sv
package missunit_pkg;

  // the last port is the write port
  localparam int unsigned NUM_PORTS    = 3;

  // address split is tag | index | offset
  localparam int unsigned PADDR_WIDTH  = 16;
  localparam int unsigned DATA_WIDTH   = 32;
  localparam int unsigned SET_ASSOC    = 4;
  localparam int unsigned WAY_WIDTH    = 2;
  localparam int unsigned OFFSET_WIDTH = 3;
  localparam int unsigned LINE_WIDTH   = 64;
  localparam int unsigned IDX_WIDTH    = 4;
  localparam int unsigned NUM_LINES    = 16;
  localparam int unsigned TAG_WIDTH    = PADDR_WIDTH - IDX_WIDTH - OFFSET_WIDTH;
  localparam int unsigned TID_WIDTH    = 2;

  // store tracking
  localparam int unsigned MAX_STORES   = 3;
  localparam int unsigned STCNT_WIDTH  = $clog2(MAX_STORES + 1);

  typedef logic [1:0] port_idx_t;

  // FLUSH comes first so that the reset value is the flush state
  typedef enum logic [2:0] {FLUSH, IDLE, DRAIN, STORE_WAIT, LOAD_WAIT} ctrl_state_e;

  typedef enum logic {REQ_LOAD, REQ_STORE} req_type_e;

  typedef enum logic [1:0] {RTRN_LOAD_ACK, RTRN_STORE_ACK, RTRN_OTHER} rtrn_type_e;

  // request of one miss port held stable until acked
  typedef struct packed {
    logic                   we;
    logic                   nc;
    logic [PADDR_WIDTH-1:0] paddr;
    logic [2:0]             size;
    logic [DATA_WIDTH-1:0]  wdata;
    logic [TID_WIDTH-1:0]   id;
    logic [SET_ASSOC-1:0]   vld_bits;
  } miss_req_t;

  // request towards memory
  typedef struct packed {
    req_type_e              rtype;
    logic [TID_WIDTH-1:0]   tid;
    logic                   nc;
    logic [WAY_WIDTH-1:0]   way;
    logic [PADDR_WIDTH-1:0] paddr;
    logic [2:0]             size;
    logic [DATA_WIDTH-1:0]  data;
  } mem_req_t;

  // memory return always carries a full line
  typedef struct packed {
    rtrn_type_e             rtype;
    logic [TID_WIDTH-1:0]   tid;
    logic [LINE_WIDTH-1:0]  data;
  } mem_rtrn_t;

  // write port of the cache memory
  typedef struct packed {
    logic                    vld;
    logic                    nc;
    logic [SET_ASSOC-1:0]    we;
    logic [TAG_WIDTH-1:0]    tag;
    logic [IDX_WIDTH-1:0]    idx;
    logic [LINE_WIDTH-1:0]   data;
    logic [LINE_WIDTH/8-1:0] be;
    logic [SET_ASSOC-1:0]    vld_bits;
  } cl_wr_t;

  // pending read miss
  typedef struct packed {
    logic [PADDR_WIDTH-1:0] paddr;
    logic                   nc;
    logic [TID_WIDTH-1:0]   id;
    logic [WAY_WIDTH-1:0]   repl_way;
    port_idx_t              port;
  } mshr_t;

endpackage
